//--- Makefile
VERILATOR ?= verilator
TOP       := tb_design_user_logic
FILELIST  := project.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps
VFLAGS    += --top-module $(TOP) -Mdir $(OBJ_DIR)
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

# Build the simulation executable from the file list
compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# Exit status of the simulation is the pass or fail result
run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- design_user_logic.sv
`timescale 1ns/1ps
`default_nettype none

`include "tuple_defs.svh"

module design_user_logic (
    input  wire                           aclk,
    input  wire                           reset,

    // Host sink
    input  wire                           sink_valid,
    output logic                          sink_ready,
    input  wire tuple_pkg::stream_beat_t  sink_beat,

    // Host source
    output logic                          src_valid,
    input  wire                           src_ready,
    output tuple_pkg::stream_beat_t       src_beat
);

    import tuple_pkg::*;

    tuple_t in_tuple;

    logic   tree_valid;
    logic   tree_ready;
    sum_t   tree_sum;
    sum_t   rd_sum;

    // tkeep, tid and tlast of the sink are not needed
    assign in_tuple = tuple_t'(sink_beat.tdata);

    tuple_adder_tree u_adder (
        .aclk      (aclk),
        .reset     (reset),
        .in_valid  (sink_valid),
        .in_ready  (sink_ready),
        .in_tuple  (in_tuple),
        .out_valid (tree_valid),
        .out_ready (tree_ready),
        .out_sum   (tree_sum)
    );

    stream_fifo #(
        .DEPTH (`RES_FIFO_DEPTH),
        .WIDTH (`FIELD_W)
    ) u_res_fifo (
        .aclk     (aclk),
        .reset    (reset),
        .wr_valid (tree_valid),
        .wr_ready (tree_ready),
        .wr_data  (tree_sum),
        .rd_valid (src_valid),
        .rd_ready (src_ready),
        .rd_data  (rd_sum)
    );

    // Sum in the low word, everything else zero, all bytes kept
    always_comb begin
        src_beat       = '0;
        src_beat.tdata = {{(`STREAM_W - `FIELD_W){1'b0}}, rd_sum};
        src_beat.tkeep = '1;
        src_beat.tid   = '0;
        src_beat.tlast = 1'b0;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+.
tuple_pkg.sv
tuple_adder_tree.sv
stream_fifo.sv
design_user_logic.sv
tb_design_user_logic.sv

//--- stream_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "tuple_defs.svh"

module stream_fifo #(
    parameter int DEPTH = `RES_FIFO_DEPTH,
    parameter int WIDTH = `FIELD_W
) (
    input  wire                       aclk,
    input  wire                       reset,

    input  wire                       wr_valid,
    output logic                      wr_ready,
    input  wire tuple_pkg::sum_t      wr_data,

    output logic                      rd_valid,
    input  wire                       rd_ready,
    output tuple_pkg::sum_t           rd_data
);

    import tuple_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    // Pointers wrap for free since DEPTH is a power of two
    if ((DEPTH < 2) || ((DEPTH & (DEPTH - 1)) != 0)) begin : g_bad_depth
        $error("stream_fifo: DEPTH must be a power of two, at least 2");
    end

    if (WIDTH != $bits(sum_t)) begin : g_bad_width
        $error("stream_fifo: WIDTH must match sum_t");
    end

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic             full;
    logic             do_wr;
    logic             do_rd;

    assign full     = (count == CNT_W'(DEPTH));
    assign rd_valid = (count != '0);

    // When full, a write may still go in alongside a read
    assign wr_ready = ~full | rd_ready;

    assign do_wr    = wr_valid & wr_ready;
    assign do_rd    = rd_valid & rd_ready;

    // Head entry drives the read side
    assign rd_data  = mem[rd_ptr];

    always_ff @(posedge aclk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_count_bound: assert property (
        @(posedge aclk) disable iff (reset) count <= CNT_W'(DEPTH))
        else $error("stream_fifo: count above DEPTH");

    // Overwrite of the head is only safe if it leaves this cycle
    a_no_overwrite: assert property (
        @(posedge aclk) disable iff (reset) (do_wr && full) |-> do_rd)
        else $error("stream_fifo: write into full buffer without read");

endmodule

`default_nettype wire

//--- tb_design_user_logic.sv
`timescale 1ns/1ps
`default_nettype none

`include "tuple_defs.svh"

module tb_design_user_logic;

    import tuple_pkg::*;

    localparam int NUM_CASES      = 38;
    localparam int CASE_WORDS     = `TUPLE_FIELDS + 1;
    localparam int TIMEOUT_CYCLES = 40 * NUM_CASES + 200;
    // Case 0 checks latency, 1..STREAM_LAST stream with gaps, the rest form the stall burst
    localparam int STREAM_LAST    = 25;
    localparam int HOLD_CYCLES    = 20;

    logic         aclk;
    logic         reset;
    logic         sink_valid;
    logic         sink_ready;
    stream_beat_t sink_beat;
    logic         src_valid;
    logic         src_ready;
    stream_beat_t src_beat;

    logic [`FIELD_W-1:0] case_mem [NUM_CASES*CASE_WORDS];
    sum_t                exp_q [$];

    int           cycle_count     = 0;
    int           sink_xfer_cycle = 0;
    int           src_xfer_cycle  = 0;
    int           results_seen    = 0;
    logic         random_ready    = 1'b0;
    logic         hold_low        = 1'b0;
    logic         stall_seen      = 1'b0;
    logic         prev_stalled    = 1'b0;
    stream_beat_t prev_beat       = '0;

    design_user_logic u_dut (
        .aclk       (aclk),
        .reset      (reset),
        .sink_valid (sink_valid),
        .sink_ready (sink_ready),
        .sink_beat  (sink_beat),
        .src_valid  (src_valid),
        .src_ready  (src_ready),
        .src_beat   (src_beat)
    );

    initial begin
        aclk = 1'b0;
        forever begin
            #5 aclk = ~aclk;
        end
    end

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1, "Simulation stopped at cycle %0d", cycle_count);
    endtask

    // Wrapped total of one case's fields
    function automatic sum_t add_fields(input int idx);
        sum_t acc;
        acc = '0;
        for (int i = 0; i < `TUPLE_FIELDS; i++) begin
            acc += case_mem[idx*CASE_WORDS + i];
        end
        return acc;
    endfunction

    task automatic check_case_file();
        sum_t listed;
        for (int c = 0; c < NUM_CASES; c++) begin
            listed = case_mem[c*CASE_WORDS + `TUPLE_FIELDS];
            assert (add_fields(c) == listed) else begin
                $display("Case %0d in the case file lists sum %08h but its fields add to %08h",
                         c, listed, add_fields(c));
                abort_run();
            end
        end
    endtask

    // Holds the beat until the DUT takes it; valid stays high afterwards
    task automatic send_case(input int idx);
        tuple_t tup;
        for (int i = 0; i < `TUPLE_FIELDS; i++) begin
            tup.field[i] = case_mem[idx*CASE_WORDS + i];
        end
        @(negedge aclk);
        sink_beat.tdata <= tup;
        sink_beat.tkeep <= '1;
        sink_beat.tid   <= '0;
        sink_beat.tlast <= 1'b1;
        sink_valid      <= 1'b1;
        do begin
            @(posedge aclk);
        end while (!sink_ready);
        sink_xfer_cycle = cycle_count;
        exp_q.push_back(case_mem[idx*CASE_WORDS + `TUPLE_FIELDS]);
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge aclk);
            sink_valid <= 1'b0;
        end
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0) begin
            @(negedge aclk);
        end
    endtask

    task automatic check_result(input stream_beat_t beat);
        sum_t expected;
        assert (exp_q.size() != 0) else begin
            $display("A result beat arrived with no input beat outstanding");
            abort_run();
        end
        expected = exp_q.pop_front();
        assert (beat.tdata[`FIELD_W-1:0] == expected) else begin
            $display("Fail src_beat.tdata[31:0]: got %08h expected %08h",
                     beat.tdata[`FIELD_W-1:0], expected);
            abort_run();
        end
        assert (beat.tdata[`STREAM_W-1:`FIELD_W] == '0) else begin
            $display("Fail src_beat.tdata[511:32]: got %h expected 0",
                     beat.tdata[`STREAM_W-1:`FIELD_W]);
            abort_run();
        end
        assert (beat.tkeep == '1) else begin
            $display("Fail src_beat.tkeep: got %h expected %h", beat.tkeep, {(`STREAM_W/8){1'b1}});
            abort_run();
        end
        assert (beat.tid == '0 && beat.tlast == 1'b0) else begin
            $display("Fail src_beat.tid/tlast: got %h/%h expected 00/0", beat.tid, beat.tlast);
            abort_run();
        end
        results_seen++;
        src_xfer_cycle = cycle_count;
    endtask

    always @(posedge aclk) begin
        cycle_count <= cycle_count + 1;
        assert (cycle_count < TIMEOUT_CYCLES) else begin
            $display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    // Source side ready pattern
    initial begin
        src_ready = 1'b1;
        forever begin
            @(negedge aclk);
            if (hold_low) begin
                src_ready <= 1'b0;
            end else if (random_ready) begin
                src_ready <= ($urandom % 4) != 0;
            end else begin
                src_ready <= 1'b1;
            end
        end
    end

    // Monitor on the source port
    always @(posedge aclk) begin
        if (reset) begin
            prev_stalled <= 1'b0;
        end else begin
            if (prev_stalled) begin
                assert (src_valid && src_beat == prev_beat) else begin
                    $display("Fail src_beat: got %h (valid %h) expected %h (valid 1) after a stall",
                             src_beat, src_valid, prev_beat);
                    abort_run();
                end
            end
            if (src_valid && src_ready) begin
                check_result(src_beat);
            end
            prev_stalled <= src_valid && !src_ready;
            prev_beat    <= src_beat;
        end
    end

    initial begin
        void'($urandom(32'hc638a2c3));
        reset      = 1'b1;
        sink_valid = 1'b0;
        sink_beat  = '0;
        $readmemh("tuple_cases.txt", case_mem);
        check_case_file();
        repeat (10) @(posedge aclk);
        @(negedge aclk);
        reset <= 1'b0;

        assert (!src_valid && sink_ready) else begin
            $display("Fail src_valid/sink_ready after reset: got %h/%h expected 0/1",
                     src_valid, sink_ready);
            abort_run();
        end

        // Single beat into an empty pipeline
        send_case(0);
        idle_cycles(1);
        wait_drained();
        assert (src_xfer_cycle - sink_xfer_cycle == 5) else begin
            $display("Fail latency: got %h expected %h cycles",
                     src_xfer_cycle - sink_xfer_cycle, 5);
            abort_run();
        end

        // Random gaps on the sink, random ready on the source
        @(posedge aclk);
        random_ready = 1'b1;
        for (int c = 1; c <= STREAM_LAST; c++) begin
            send_case(c);
            idle_cycles($urandom % 3);
        end
        idle_cycles(1);
        wait_drained();

        // Back-to-back burst into a blocked source port
        @(posedge aclk);
        random_ready = 1'b0;
        hold_low     = 1'b1;
        fork
            begin
                for (int c = STREAM_LAST + 1; c < NUM_CASES; c++) begin
                    send_case(c);
                end
                idle_cycles(1);
            end
            begin
                repeat (HOLD_CYCLES) begin
                    @(posedge aclk);
                    if (!sink_ready) begin
                        stall_seen = 1'b1;
                    end
                end
                hold_low = 1'b0;
            end
        join
        wait_drained();
        assert (stall_seen) else begin
            $display("sink_ready never dropped while src_ready was held low");
            abort_run();
        end

        // Nothing more may come out
        repeat (10) @(negedge aclk);
        if (results_seen == NUM_CASES && exp_q.size() == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("Fail results_seen: got %h expected %h", results_seen, NUM_CASES);
            abort_run();
        end
    end

endmodule

`default_nettype wire

//--- tuple_adder_tree.sv
`timescale 1ns/1ps
`default_nettype none

`include "tuple_defs.svh"

module tuple_adder_tree (
    input  wire                       aclk,
    input  wire                       reset,

    input  wire                       in_valid,
    output logic                      in_ready,
    input  wire tuple_pkg::tuple_t    in_tuple,

    output logic                      out_valid,
    input  wire                       out_ready,
    output tuple_pkg::sum_t           out_sum
);

    import tuple_pkg::*;

    // Partial sums per level
    localparam int L1_N = `TUPLE_FIELDS / 2;
    localparam int L2_N = L1_N / 2;
    localparam int L3_N = L2_N / 2;

    sum_t [L1_N-1:0] l1_sum;
    sum_t [L2_N-1:0] l2_sum;
    sum_t [L3_N-1:0] l3_sum;
    sum_t            l4_sum;

    // Bit k is the valid of level k+1
    logic [3:0]      stage_valid;
    logic            advance;

    // Whole pipeline moves as one; it only waits on a stalled head
    assign advance   = ~(stage_valid[3] & ~out_ready);
    assign in_ready  = advance;

    assign out_valid = stage_valid[3];
    assign out_sum   = l4_sum;

    always_ff @(posedge aclk) begin
        if (reset) begin
            stage_valid <= '0;
        end else if (advance) begin
            stage_valid <= {stage_valid[2:0], in_valid};
        end
    end

    // Level 1 adds pairs of input fields
    always_ff @(posedge aclk) begin
        if (advance) begin
            for (int i = 0; i < L1_N; i++) begin
                l1_sum[i] <= in_tuple.field[2*i] + in_tuple.field[2*i+1];
            end
        end
    end

    // Level 2
    always_ff @(posedge aclk) begin
        if (advance) begin
            for (int i = 0; i < L2_N; i++) begin
                l2_sum[i] <= l1_sum[2*i] + l1_sum[2*i+1];
            end
        end
    end

    // Level 3
    always_ff @(posedge aclk) begin
        if (advance) begin
            for (int i = 0; i < L3_N; i++) begin
                l3_sum[i] <= l2_sum[2*i] + l2_sum[2*i+1];
            end
        end
    end

    // Level 4 makes the final sum; carries out of bit 31 are dropped
    always_ff @(posedge aclk) begin
        if (advance) begin
            l4_sum <= l3_sum[0] + l3_sum[1];
        end
    end

    // A stalled result must not change under the consumer
    property p_sum_held_on_stall;
        @(posedge aclk) disable iff (reset)
            (out_valid && !out_ready) |=> $stable(out_sum);
    endproperty

    a_sum_held_on_stall: assert property (p_sum_held_on_stall)
        else $error("tuple_adder_tree: out_sum moved while stalled");

    // Stage valids are the only control state here
    property p_valid_known;
        @(posedge aclk) disable iff (reset)
            !$isunknown(stage_valid);
    endproperty

    a_valid_known: assert property (p_valid_known)
        else $error("tuple_adder_tree: stage valid unknown");

endmodule

`default_nettype wire

//--- tuple_cases.txt
// One case per line: fields 0 to 15 in hex, field 0 first
// Last column is the expected sum of the sixteen fields, modulo 2^32
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFF0
00000001 00000002 00000003 00000004 00000005 00000006 00000007 00000008 00000009 0000000A 0000000B 0000000C 0000000D 0000000E 0000000F 00000010 00000088
10000000 10000000 10000000 10000000 10000000 10000000 10000000 10000000 10000000 10000000 10000000 10000000 10000000 10000000 10000000 10000000 00000000
80000000 80000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
FFFFFFFF 00000001 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000001 00000001 00000001 00000001 00000001 00000001 00000001 00000001 00000001 00000001 00000001 00000001 00000001 00000001 00000001 00000001 00000010
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 12345678 12345678
12345678 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 12345678
11111111 11111111 11111111 11111111 11111111 11111111 11111111 11111111 11111111 11111111 11111111 11111111 11111111 11111111 11111111 11111111 11111110
FFFFFFFF 00000001 FFFFFFFF 00000001 FFFFFFFF 00000001 FFFFFFFF 00000001 FFFFFFFF 00000001 FFFFFFFF 00000001 FFFFFFFF 00000001 FFFFFFFF 00000001 00000000
0000FFFF 0000FFFF 0000FFFF 0000FFFF 0000FFFF 0000FFFF 0000FFFF 0000FFFF 0000FFFF 0000FFFF 0000FFFF 0000FFFF 0000FFFF 0000FFFF 0000FFFF 0000FFFF 000FFFF0
FFFF0000 FFFF0000 FFFF0000 FFFF0000 FFFF0000 FFFF0000 FFFF0000 FFFF0000 FFFF0000 FFFF0000 FFFF0000 FFFF0000 FFFF0000 FFFF0000 FFFF0000 FFFF0000 FFF00000
01000000 02000000 03000000 04000000 05000000 06000000 07000000 08000000 09000000 0A000000 0B000000 0C000000 0D000000 0E000000 0F000000 10000000 88000000
7FFFFFFF 7FFFFFFF 7FFFFFFF 7FFFFFFF 7FFFFFFF 7FFFFFFF 7FFFFFFF 7FFFFFFF 7FFFFFFF 7FFFFFFF 7FFFFFFF 7FFFFFFF 7FFFFFFF 7FFFFFFF 7FFFFFFF 7FFFFFFF FFFFFFF0
80000000 80000000 80000000 80000000 80000000 80000000 80000000 80000000 80000000 80000000 80000000 80000000 80000000 80000000 80000000 80000000 00000000
00000100 00000100 00000100 00000100 00000100 00000100 00000100 00000100 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000800
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00010000 00010000 00010000 00010000 00010000 00010000 00010000 00010000 00080000
DEADBEEF 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000001 DEADBEF0
00000000 00000001 00000002 00000003 00000004 00000005 00000006 00000007 00000008 00000009 0000000A 0000000B 0000000C 0000000D 0000000E 0000000F 00000078
F0000000 F0000000 F0000000 F0000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 C0000000
00000001 00000002 00000004 00000008 00000010 00000020 00000040 00000080 00000100 00000200 00000400 00000800 00001000 00002000 00004000 00008000 0000FFFF
00010000 00020000 00040000 00080000 00100000 00200000 00400000 00800000 01000000 02000000 04000000 08000000 10000000 20000000 40000000 80000000 FFFF0000
00000001 00000004 00000010 00000040 00000100 00000400 00001000 00004000 00010000 00040000 00100000 00400000 01000000 04000000 10000000 40000000 55555555
00000002 00000008 00000020 00000080 00000200 00000800 00002000 00008000 00020000 00080000 00200000 00800000 02000000 08000000 20000000 80000000 AAAAAAAA
12345678 12345678 12345678 12345678 12345678 12345678 12345678 12345678 12345678 12345678 12345678 12345678 12345678 12345678 12345678 12345678 23456780
0F0F0F0F 0F0F0F0F 0F0F0F0F 0F0F0F0F 0F0F0F0F 0F0F0F0F 0F0F0F0F 0F0F0F0F 0F0F0F0F 0F0F0F0F 0F0F0F0F 0F0F0F0F 0F0F0F0F 0F0F0F0F 0F0F0F0F 0F0F0F0F F0F0F0F0
0FFFFFFF 0FFFFFFF 0FFFFFFF 0FFFFFFF 0FFFFFFF 0FFFFFFF 0FFFFFFF 0FFFFFFF 0FFFFFFF 0FFFFFFF 0FFFFFFF 0FFFFFFF 0FFFFFFF 0FFFFFFF 0FFFFFFF 0FFFFFFF FFFFFFF0
10000001 10000001 10000001 10000001 10000001 10000001 10000001 10000001 10000001 10000001 10000001 10000001 10000001 10000001 10000001 10000001 00000010
00000001 00000001 00000001 00000001 00000001 00000001 00000001 00000001 00000001 00000001 00000001 00000001 00000001 00000001 00000001 FFFFFFF1 00000000
00000100 00000200 00000300 00000400 00000500 00000600 00000700 00000800 00000900 00000A00 00000B00 00000C00 00000D00 00000E00 00000F00 00001000 00008800
CAFEF00D 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 CAFEF00D
CAFEF00D CAFEF00D 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 95FDE01A
00000003 00000003 00000003 00000003 00000003 00000003 00000003 00000003 00000003 00000003 00000003 00000003 00000003 00000003 00000003 00000003 00000030
88888888 88888888 88888888 88888888 88888888 88888888 88888888 88888888 88888888 88888888 88888888 88888888 88888888 88888888 88888888 88888888 88888880
FFFFFFFF 00000000 FFFFFFFF 00000000 FFFFFFFF 00000000 FFFFFFFF 00000000 FFFFFFFF 00000000 FFFFFFFF 00000000 FFFFFFFF 00000000 FFFFFFFF 00000000 FFFFFFF8
00000010 00000020 00000030 00000040 00000050 00000060 00000070 00000080 00000090 000000A0 000000B0 000000C0 000000D0 000000E0 000000F0 00000100 00000880
00000001 FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFF2

//--- tuple_defs.svh
`ifndef TUPLE_DEFS_SVH
`define TUPLE_DEFS_SVH

// Unsigned fields carried by one host beat
`define TUPLE_FIELDS 16

// Width of one field, and of the wrapped sum
`define FIELD_W 32

// Host stream data width
`define STREAM_W 512

// Result buffer entries in front of the source port
`define RES_FIFO_DEPTH 4

`endif

//--- tuple_pkg.sv
`default_nettype none

`include "tuple_defs.svh"

package tuple_pkg;

    // Sum wraps modulo 2^FIELD_W
    typedef logic [`FIELD_W-1:0] sum_t;

    // Field 0 sits in the lowest bits of tdata
    typedef struct packed {
        sum_t [`TUPLE_FIELDS-1:0] field;
    } tuple_t;

    // One host stream beat in the layout of the shell's AXI4SR port
    typedef struct packed {
        logic [`STREAM_W-1:0]   tdata;
        logic [`STREAM_W/8-1:0] tkeep;
        logic [5:0]             tid;
        logic                   tlast;
    } stream_beat_t;

endpackage

`default_nettype wire
